// ==== sim.f ====
hw/sens_cmd_pkg.sv
hw/sens_frame_pkg.sv
hw/sens_cmd_decoder.sv
hw/sens_channel.sv
hw/sens_status_router.sv
hw/sensors_top.sv
verification/sensors_status_checker.sv
verification/sensors_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the sensor testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f sim.f --top-module sensors_tb --Mdir "$OBJ" -o sensors_tb_sim
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "build failed with status $build_status"
    exit 1
fi

"./$OBJ/sensors_tb_sim" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -qF '*** FAILED ***' "$LOG"; then
    echo "simulation reported failure"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

echo "simulation finished without failure"
exit 0

// ==== verification/sensors_tb.sv ====
// sensor frame sync testbench
module sensors_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_CHN    = 4;
    localparam int RST_CYCLES = 16;
    localparam int WR_CYCLES  = 13;   // four bytes plus settle time
    localparam int NUM_WR     = 20;
    localparam int PKT_CYCLES = 10;   // grant, random wait, data byte
    localparam int NUM_PKT    = 20;
    localparam int MISC_CYC   = 200;  // frame starts, lines, idle checks
    localparam int WDOG_CYCLES = RST_CYCLES + NUM_WR * WR_CYCLES
                               + NUM_PKT * PKT_CYCLES + MISC_CYC + 200;

    logic                    mclk;
    logic                    rst;
    sens_cmd_pkg::cmd_byte_t cmd_ad;
    logic                    cmd_stb;
    logic [NUM_CHN-1:0]      frame_start;
    logic [NUM_CHN-1:0]      line_end;
    logic                    status_start;
    sens_cmd_pkg::cmd_byte_t status_ad;
    logic                    status_rq;
    logic [NUM_CHN-1:0]      sof_out_mclk;
    logic [NUM_CHN-1:0]      sof_late_mclk;

    int seed    = 57;            // reader delay stream
    int rr_last = NUM_CHN - 1;   // last channel the router served

    sensors_top #(
        .NUM_CHN (NUM_CHN)
    ) uut (
        .mclk          (mclk),
        .rst           (rst),
        .cmd_ad        (cmd_ad),
        .cmd_stb       (cmd_stb),
        .frame_start   (frame_start),
        .line_end      (line_end),
        .status_start  (status_start),
        .status_ad     (status_ad),
        .status_rq     (status_rq),
        .sof_out_mclk  (sof_out_mclk),
        .sof_late_mclk (sof_late_mclk)
    );

    initial begin
        mclk = 1'b0;
        forever #50 mclk = ~mclk;  // 100 ns period
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_val(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (exp !== act) begin
            $display("[ERROR] %0d ns: %s expected 'h%0h, got 'h%0h", $time, name, exp, act);
            abort_run("stopping at the first mismatch");
        end
    endtask

    // AL, AH, D0, D1 on consecutive cycles, strobe with AL
    task automatic send_cmd(input sens_cmd_pkg::cmd_addr_t addr,
                            input sens_cmd_pkg::cmd_data_t data);
        @(negedge mclk);
        cmd_stb = 1'b1;
        cmd_ad  = addr[7:0];
        @(negedge mclk);
        cmd_stb = 1'b0;
        cmd_ad  = addr[15:8];
        @(negedge mclk);
        cmd_ad = data[7:0];
        @(negedge mclk);
        cmd_ad = data[15:8];
        @(negedge mclk);
        cmd_ad = '0;
        repeat (8) @(negedge mclk);  // register in effect by now
    endtask

    task automatic write_reg(input int chn, input sens_cmd_pkg::reg_sel_t regsel,
                             input sens_cmd_pkg::cmd_data_t data);
        sens_cmd_pkg::cmd_addr_t addr;
        addr = sens_cmd_pkg::SENSOR_GROUP_ADDR + 16'(chn) * sens_cmd_pkg::SENSOR_BASE_INC
             + 16'(regsel);
        send_cmd(addr, data);
    endtask

    // one-cycle frame starts, sof expected on the next edge
    task automatic fire_frames(input logic [NUM_CHN-1:0] mask,
                               input logic [NUM_CHN-1:0] exp_sof);
        @(negedge mclk);
        frame_start = mask;
        @(negedge mclk);
        frame_start = '0;
        check_val("sof_out_mclk", 8'(exp_sof), 8'(sof_out_mclk));
    endtask

    task automatic pulse_lines(input logic [NUM_CHN-1:0] mask);
        @(negedge mclk);
        line_end = mask;
        @(negedge mclk);
        line_end = '0;
    endtask

    task automatic expect_quiet(input int cycles);
        repeat (cycles) begin
            @(negedge mclk);
            check_val("status_rq", 8'd0, 8'(status_rq));
            check_val("sof_out_mclk", 8'd0, 8'(sof_out_mclk));
            check_val("sof_late_mclk", 8'd0, 8'(sof_late_mclk));
        end
    endtask

    // answers one packet with a random 0..3 cycle delay
    task automatic read_packet(input sens_cmd_pkg::cmd_byte_t exp_addr,
                               input sens_cmd_pkg::cmd_byte_t exp_data);
        int wait_cyc;
        int dly;
        wait_cyc = 0;
        while (status_rq !== 1'b1) begin
            @(negedge mclk);
            wait_cyc++;
            if (wait_cyc > 20) abort_run("timeout: no status request from the router");
        end
        check_val("status_ad", exp_addr, status_ad);
        dly = $random(seed) & 3;
        repeat (dly) begin
            @(negedge mclk);
            check_val("status_rq", 8'd1, 8'(status_rq));  // held while stalled
        end
        status_start = 1'b1;
        @(negedge mclk);
        status_start = 1'b0;
        check_val("status_rq", 8'd0, 8'(status_rq));
        check_val("status_ad", exp_data, status_ad);  // data byte follows
        rr_last = int'(exp_addr - sens_cmd_pkg::STATUS_ADDR_BASE);
    endtask

    task automatic check_after_reset();
        expect_quiet(4);
        fire_frames('1, '0);   // all channels still disabled
        expect_quiet(6);
    endtask

    task automatic enable_one_channel();
        write_reg(1, sens_cmd_pkg::REG_MODE, 16'h0001);
        for (int n = 1; n <= 3; n++) begin
            fire_frames(4'b0010, 4'b0010);
            read_packet(sens_cmd_pkg::STATUS_ADDR_BASE + 8'd1, 8'(n));
        end
    endtask

    task automatic decimate_frames();
        int mult;
        int cnt;
        mult = 2;
        cnt  = 0;
        write_reg(2, sens_cmd_pkg::REG_SYNC_MULT, 16'(mult));
        write_reg(2, sens_cmd_pkg::REG_MODE, 16'h0001);
        for (int i = 0; i < 9; i++) begin
            if (i % (mult + 1) == 0) begin  // first of each group
                cnt++;
                fire_frames(4'b0100, 4'b0100);
                read_packet(sens_cmd_pkg::STATUS_ADDR_BASE + 8'd2, 8'(cnt));
            end else begin
                fire_frames(4'b0100, 4'b0000);
                expect_quiet(3);
            end
        end
    endtask

    task automatic late_sof_lines();
        write_reg(3, sens_cmd_pkg::REG_SYNC_LATE, 16'd3);
        write_reg(3, sens_cmd_pkg::REG_MODE, 16'h0001);
        fire_frames(4'b1000, 4'b1000);
        check_val("sof_late_mclk", 8'd0, 8'(sof_late_mclk));
        read_packet(sens_cmd_pkg::STATUS_ADDR_BASE + 8'd3, 8'd1);
        for (int l = 1; l <= 3; l++) begin
            pulse_lines(4'b1000);
            check_val("sof_late_mclk", (l == 3) ? 8'h08 : 8'h00, 8'(sof_late_mclk));
        end
        @(negedge mclk);
        check_val("sof_late_mclk", 8'd0, 8'(sof_late_mclk));  // single pulse
        write_reg(3, sens_cmd_pkg::REG_SYNC_LATE, 16'd0);
        fire_frames(4'b1000, 4'b1000);
        check_val("sof_late_mclk", 8'h08, 8'(sof_late_mclk));  // together with sof
        read_packet(sens_cmd_pkg::STATUS_ADDR_BASE + 8'd3, 8'd2);
    endtask

    task automatic round_robin_all();
        int nxt;
        for (int k = 0; k < NUM_CHN; k++) begin
            write_reg(k, sens_cmd_pkg::REG_MODE, 16'h0000);  // clears counts
        end
        write_reg(2, sens_cmd_pkg::REG_SYNC_MULT, 16'd0);
        for (int k = 0; k < NUM_CHN; k++) begin
            write_reg(k, sens_cmd_pkg::REG_MODE, 16'h0001);
        end
        for (int r = 1; r <= 2; r++) begin
            fire_frames('1, '1);
            for (int i = 0; i < NUM_CHN; i++) begin
                nxt = (rr_last + 1) % NUM_CHN;  // round-robin after last served
                read_packet(sens_cmd_pkg::STATUS_ADDR_BASE + 8'(nxt), 8'(r));
            end
        end
    endtask

    task automatic ignore_unmapped();
        write_reg(0, sens_cmd_pkg::REG_MODE, 16'h0000);
        send_cmd(sens_cmd_pkg::SENSOR_GROUP_ADDR + 16'h0100, 16'h0001);  // past last channel
        write_reg(0, 2'd1, 16'h0001);                                    // unused offset
        fire_frames(4'b0001, 4'b0000);
        expect_quiet(6);
    endtask

    initial begin
        cmd_ad       = '0;
        cmd_stb      = 1'b0;
        frame_start  = '0;
        line_end     = '0;
        status_start = 1'b0;
        rst          = 1'b1;
        repeat (RST_CYCLES) @(negedge mclk);
        rst = 1'b0;
        check_after_reset();
        enable_one_channel();
        decimate_frames();
        late_sof_lines();
        round_robin_all();
        ignore_unmapped();
        $display("*** PASSED ***");
        $finish;
    end

    // run limit from summed test lengths
    initial begin
        repeat (WDOG_CYCLES) @(posedge mclk);
        abort_run("timeout: tests did not finish in time");
    end

endmodule

// ==== verification/sensors_status_checker.sv ====
// status port handshake assertions
module sensors_status_checker #(
    parameter int NUM_CHN = 4
) (
    input logic               mclk,
    input logic               rst,
    input logic [NUM_CHN-1:0] stat_rq,
    input logic [NUM_CHN-1:0] stat_grant,
    input logic               status_rq,
    input logic               status_start
);
    timeunit 1ns;
    timeprecision 100ps;

    // request held until the address byte is taken
    rq_held: assert property (@(posedge mclk) disable iff (rst)
        status_rq && !status_start |=> status_rq)
        else $error("status_rq dropped before status_start");

    // one grant at a time, only to a requesting channel
    grant_onehot: assert property (@(posedge mclk) disable iff (rst)
        $onehot0(stat_grant) && ((stat_grant & ~stat_rq) == '0))
        else $error("stat_grant not one-hot or given to an idle channel");

    rq_falls: assert property (@(posedge mclk) disable iff (rst)
        status_rq && status_start |=> !status_rq)
        else $error("status_rq still high after status_start");

    // at least one low cycle between packets
    rq_gap: assert property (@(posedge mclk) disable iff (rst)
        $fell(status_rq) |=> !status_rq)
        else $error("status_rq low for only one cycle");

endmodule

bind sens_status_router sensors_status_checker #(
    .NUM_CHN (NUM_CHN)
) i_status_checker (
    .mclk         (mclk),
    .rst          (rst),
    .stat_rq      (stat_rq),
    .stat_grant   (stat_grant),
    .status_rq    (status_rq),
    .status_start (status_start)
);

// ==== hw/sensors_top.sv ====
// sensor frame sync subsystem
module sensors_top #(
    parameter int NUM_CHN = 4
) (
    input  logic                     mclk,
    input  logic                     rst,
    input  sens_cmd_pkg::cmd_byte_t  cmd_ad,
    input  logic                     cmd_stb,
    input  logic [NUM_CHN-1:0]       frame_start,
    input  logic [NUM_CHN-1:0]       line_end,
    input  logic                     status_start,
    output sens_cmd_pkg::cmd_byte_t  status_ad,
    output logic                     status_rq,
    output logic [NUM_CHN-1:0]       sof_out_mclk,
    output logic [NUM_CHN-1:0]       sof_late_mclk
);

    logic [NUM_CHN-1:0]       wr_en;                  // per-channel write strobes
    sens_cmd_pkg::reg_sel_t   wr_reg;
    sens_cmd_pkg::cmd_data_t  wr_data;
    logic [NUM_CHN-1:0]       stat_rq;
    logic [NUM_CHN-1:0]       stat_grant;
    sens_cmd_pkg::cmd_byte_t  stat_data [NUM_CHN];

    sens_cmd_decoder #(
        .NUM_CHN (NUM_CHN)
    ) i_decoder (
        .mclk    (mclk),
        .rst     (rst),
        .cmd_ad  (cmd_ad),
        .cmd_stb (cmd_stb),
        .wr_en   (wr_en),
        .wr_reg  (wr_reg),
        .wr_data (wr_data)
    );

    for (genvar k = 0; k < NUM_CHN; k++) begin : g_chn
        sens_channel #(
            .CHN (k)
        ) i_channel (
            .mclk          (mclk),
            .rst           (rst),
            .wr_en         (wr_en[k]),
            .wr_reg        (wr_reg),
            .wr_data       (wr_data),
            .frame_start   (frame_start[k]),
            .line_end      (line_end[k]),
            .stat_grant    (stat_grant[k]),
            .sof_out_mclk  (sof_out_mclk[k]),
            .sof_late_mclk (sof_late_mclk[k]),
            .stat_rq       (stat_rq[k]),
            .stat_data     (stat_data[k])
        );
    end

    sens_status_router #(
        .NUM_CHN (NUM_CHN)
    ) i_router (
        .mclk         (mclk),
        .rst          (rst),
        .stat_rq      (stat_rq),
        .stat_data    (stat_data),
        .status_start (status_start),
        .stat_grant   (stat_grant),
        .status_ad    (status_ad),
        .status_rq    (status_rq)
    );

endmodule

// ==== hw/sens_status_router.sv ====
// round-robin status router
// two-byte packets onto the status port
module sens_status_router #(
    parameter int NUM_CHN = 4
) (
    input  logic                     mclk,
    input  logic                     rst,
    input  logic [NUM_CHN-1:0]       stat_rq,
    input  sens_cmd_pkg::cmd_byte_t  stat_data [NUM_CHN],
    input  logic                     status_start,  // address byte taken
    output logic [NUM_CHN-1:0]       stat_grant,
    output sens_cmd_pkg::cmd_byte_t  status_ad,
    output logic                     status_rq
);

    localparam int IDX_W = (NUM_CHN > 1) ? $clog2(NUM_CHN) : 1;

    typedef enum logic [1:0] {
        ST_IDLE,  // looking for a request
        ST_ADDR,  // address byte out, waiting for status_start
        ST_DATA   // data byte out
    } state_t;

    state_t                     state;
    logic [IDX_W-1:0]           last_chn;  // last channel served
    logic [IDX_W-1:0]           sel;       // next channel to serve
    logic                       found;
    sens_frame_pkg::frame_cnt_t data_lat;  // frame count held for byte 2

    // search starts one past the last served channel
    always_comb begin
        int idx;
        found = 1'b0;
        sel   = last_chn;
        for (int i = 1; i <= NUM_CHN; i++) begin
            idx = (int'(last_chn) + i) % NUM_CHN;
            if (!found && stat_rq[idx]) begin
                found = 1'b1;
                sel   = IDX_W'(idx);
            end
        end
    end

    always_comb begin
        stat_grant = '0;
        if (state == ST_IDLE && found) stat_grant[sel] = 1'b1;  // one cycle only
    end

    always_ff @(posedge mclk) begin
        if (rst) begin
            state     <= ST_IDLE;
            status_rq <= 1'b0;
            last_chn  <= IDX_W'(NUM_CHN - 1);  // channel 0 first
        end else begin
            case (state)
                ST_IDLE: if (found) begin
                    state     <= ST_ADDR;
                    status_rq <= 1'b1;
                    last_chn  <= sel;
                end
                ST_ADDR: if (status_start) begin  // wait as long as needed
                    state     <= ST_DATA;
                    status_rq <= 1'b0;
                end
                default: state <= ST_IDLE;        // keeps rq low one more cycle
            endcase
        end
    end

    always_ff @(posedge mclk) begin
        if (state == ST_IDLE && found) begin
            status_ad <= sens_cmd_pkg::STATUS_ADDR_BASE + sens_cmd_pkg::cmd_byte_t'(sel);
            data_lat  <= stat_data[sel];
        end else if (state == ST_ADDR && status_start) begin
            status_ad <= data_lat;
        end
    end

endmodule

// ==== hw/sens_channel.sv ====
// one sensor channel
// frame decimator, late sof and status request
module sens_channel #(
    parameter int CHN = 0  // channel index
) (
    input  logic                     mclk,
    input  logic                     rst,
    input  logic                     wr_en,         // own bit from decoder
    input  sens_cmd_pkg::reg_sel_t   wr_reg,
    input  sens_cmd_pkg::cmd_data_t  wr_data,
    input  logic                     frame_start,   // single-cycle pulse
    input  logic                     line_end,      // single-cycle pulse
    input  logic                     stat_grant,    // packet taken by router
    output logic                     sof_out_mclk,
    output logic                     sof_late_mclk,
    output logic                     stat_rq,       // level until granted
    output sens_cmd_pkg::cmd_byte_t  stat_data
);

    logic                        en;         // mode register enable bit
    sens_frame_pkg::frame_mult_t mult;
    sens_frame_pkg::line_cnt_t   late;
    sens_frame_pkg::frame_mult_t grp_cnt;    // position in frame group
    sens_frame_pkg::line_cnt_t   line_cnt;   // lines since accepted start
    logic                        late_pend;  // waiting for late sof
    sens_frame_pkg::frame_cnt_t  frame_cnt;
    logic                        mult_wr;
    logic                        accept;     // frame start goes through

    // channel index shows up in the status address byte built by the router
    if (CHN > 8'hff - sens_cmd_pkg::STATUS_ADDR_BASE) begin : g_chn_range
        $error("channel index does not fit the status address byte");
    end

    assign mult_wr   = wr_en && (wr_reg == sens_cmd_pkg::REG_SYNC_MULT);
    assign accept    = en && frame_start && (grp_cnt == '0);  // first of each group
    assign stat_data = frame_cnt;                             // newest count

    always_ff @(posedge mclk) begin
        if (rst) begin
            en   <= 1'b0;
            mult <= '0;
            late <= sens_frame_pkg::SYNC_LATE_DFLT;
        end else if (wr_en) begin
            case (wr_reg)
                sens_cmd_pkg::REG_MODE:      en   <= wr_data[sens_cmd_pkg::MODE_EN_BIT];
                sens_cmd_pkg::REG_SYNC_MULT: mult <= wr_data[7:0];
                sens_cmd_pkg::REG_SYNC_LATE: late <= wr_data[7:0];
                default: ;                                    // offset 1 never decoded
            endcase
        end
    end

    // frame-combining counter, restarts on enable and on mult write
    always_ff @(posedge mclk) begin
        if (rst || !en || mult_wr) begin
            grp_cnt <= '0;
        end else if (frame_start) begin
            grp_cnt <= (grp_cnt >= mult) ? '0 : grp_cnt + 1'b1;
        end
    end

    always_ff @(posedge mclk) begin
        if (rst || !en) begin                  // disable drops count and request
            sof_out_mclk <= 1'b0;
            frame_cnt    <= '0;
            stat_rq      <= 1'b0;
        end else begin
            sof_out_mclk <= accept;            // 1 cycle after frame_start
            if (accept) begin
                frame_cnt <= frame_cnt + 1'b1;
                stat_rq   <= 1'b1;             // wins over a grant in same cycle
            end else if (stat_grant) begin
                stat_rq   <= 1'b0;
            end
        end
    end

    // late sof line counter
    always_ff @(posedge mclk) begin
        if (rst || !en) begin
            late_pend     <= 1'b0;
            line_cnt      <= '0;
            sof_late_mclk <= 1'b0;
        end else begin
            sof_late_mclk <= 1'b0;
            if (accept) begin                  // new start restarts the count
                line_cnt      <= '0;
                late_pend     <= (late != '0);
                sof_late_mclk <= (late == '0); // with sof_out
            end else if (late_pend && line_end) begin
                line_cnt <= line_cnt + 1'b1;
                if ((line_cnt + 1'b1) >= late) begin  // late-th line done
                    late_pend     <= 1'b0;
                    sof_late_mclk <= 1'b1;
                end
            end
        end
    end

endmodule

// ==== hw/sens_cmd_decoder.sv ====
// byte-serial command decoder
// AL, AH, D0, D1 into one-hot channel register writes
module sens_cmd_decoder #(
    parameter int NUM_CHN = 4
) (
    input  logic                       mclk,
    input  logic                       rst,
    input  sens_cmd_pkg::cmd_byte_t    cmd_ad,   // byte stream
    input  logic                       cmd_stb,  // with AL
    output logic [NUM_CHN-1:0]         wr_en,    // one-hot, single cycle
    output sens_cmd_pkg::reg_sel_t     wr_reg,
    output sens_cmd_pkg::cmd_data_t    wr_data
);

    sens_cmd_pkg::cmd_byte_t cmd_ad_r;   // registered bus
    logic                    cmd_stb_r;
    logic                    busy;       // command in progress
    logic [1:0]              byte_cnt;   // next byte index
    sens_cmd_pkg::cmd_addr_t addr;
    sens_cmd_pkg::cmd_byte_t data_lo;    // D0
    sens_cmd_pkg::cmd_addr_t rel;        // address inside channel block
    sens_cmd_pkg::cmd_addr_t chn_idx;
    sens_cmd_pkg::cmd_addr_t reg_off;
    logic                    hit;

    always_ff @(posedge mclk) begin
        cmd_ad_r <= cmd_ad;
    end

    always_ff @(posedge mclk) begin
        if (rst) cmd_stb_r <= 1'b0;
        else     cmd_stb_r <= cmd_stb;
    end

    assign rel     = addr - sens_cmd_pkg::SENSOR_GROUP_ADDR;
    assign chn_idx = rel / sens_cmd_pkg::SENSOR_BASE_INC;   // power of two, just a shift
    assign reg_off = rel % sens_cmd_pkg::SENSOR_BASE_INC;
    assign hit = (addr >= sens_cmd_pkg::SENSOR_GROUP_ADDR) &&
                 (chn_idx < sens_cmd_pkg::cmd_addr_t'(NUM_CHN)) &&
                 (reg_off == sens_cmd_pkg::cmd_addr_t'(sens_cmd_pkg::REG_MODE) ||
                  reg_off == sens_cmd_pkg::cmd_addr_t'(sens_cmd_pkg::REG_SYNC_MULT) ||
                  reg_off == sens_cmd_pkg::cmd_addr_t'(sens_cmd_pkg::REG_SYNC_LATE));

    always_ff @(posedge mclk) begin
        if (rst) begin
            busy     <= 1'b0;
            byte_cnt <= 2'd0;
            wr_en    <= '0;
        end else begin
            wr_en <= '0;                      // pulse only
            if (cmd_stb_r) begin              // AL, new command restarts
                busy     <= 1'b1;
                byte_cnt <= 2'd1;
            end else if (busy) begin
                byte_cnt <= byte_cnt + 1'b1;
                if (byte_cnt == 2'd3) begin   // D1 on the bus
                    busy <= 1'b0;
                    for (int i = 0; i < NUM_CHN; i++) begin
                        wr_en[i] <= hit && (chn_idx == sens_cmd_pkg::cmd_addr_t'(i));
                    end
                end
            end
        end
    end

    // address and data assembly
    always_ff @(posedge mclk) begin
        if (cmd_stb_r) begin
            addr[7:0] <= cmd_ad_r;
        end else if (busy) begin
            case (byte_cnt)
                2'd1: addr[15:8] <= cmd_ad_r;
                2'd2: data_lo    <= cmd_ad_r;
                2'd3: begin
                    wr_data <= {cmd_ad_r, data_lo};
                    wr_reg  <= sens_cmd_pkg::reg_sel_t'(reg_off);
                end
                default: ;
            endcase
        end
    end

endmodule

// ==== hw/sens_frame_pkg.sv ====
// frame sync types
package sens_frame_pkg;

    typedef logic [7:0] frame_cnt_t;   // accepted frames, also status data
    typedef logic [7:0] frame_mult_t;  // frames combined minus one
    typedef logic [7:0] line_cnt_t;    // late sof delay in lines

    localparam line_cnt_t SYNC_LATE_DFLT = 8'd15;  // late delay out of reset

endpackage

// ==== hw/sens_cmd_pkg.sv ====
// sensor command port definitions
// address map and register offsets
package sens_cmd_pkg;

    typedef logic [7:0]  cmd_byte_t;  // one byte of command/status bus
    typedef logic [15:0] cmd_addr_t;  // AL, AH
    typedef logic [15:0] cmd_data_t;  // D0, D1
    typedef logic [1:0]  reg_sel_t;   // register within one channel

    // channel block
    localparam cmd_addr_t SENSOR_GROUP_ADDR = 16'h0400;  // first channel
    localparam cmd_addr_t SENSOR_BASE_INC   = 16'h0040;  // step per channel

    // per-channel registers, offset 1 unused
    localparam reg_sel_t REG_MODE      = 2'd0;  // mode bits
    localparam reg_sel_t REG_SYNC_MULT = 2'd2;  // frames to combine minus 1
    localparam reg_sel_t REG_SYNC_LATE = 2'd3;  // lines to delay late sof

    localparam int MODE_EN_BIT = 0;  // channel enable

    // status packet address byte is base + channel
    localparam cmd_byte_t STATUS_ADDR_BASE = 8'h20;

endpackage
